// File: capture/cmos_byte_pack.sv
`timescale 1ns/10ps

module cmos_byte_pack #(
    parameter int H_ACT  = video_pkg::DEF_H_ACT,
    parameter int V_ACT  = video_pkg::DEF_V_ACT,
    parameter int H_BASE = 0
) (
    input  logic                             core_clk,
    input  logic                             rst_i,
    input  logic                             vsync_i,
    input  logic                             href_i,
    input  logic                             byte_vld_i,
    input  logic [video_pkg::CAM_BYTE_W-1:0] data_i,
    input  logic                             reverse_i,
    output logic                             push_o,
    output logic [video_pkg::PIX_W-1:0]      pix_o,
    output logic [bus_pkg::WB_ADR_W-1:0]     adr_o
);
    import video_pkg::*;
    import bus_pkg::*;

    logic                  vsync_q;     // registered camera controls
    logic                  href_q;
    logic                  href_d;      // href one cycle older, for edges
    logic                  vld_q;
    logic [CAM_BYTE_W-1:0] data_q;      // registered camera byte
    logic [CAM_BYTE_W-1:0] hi_q;        // upper half of camera word
    logic                  phase_q;     // high when lower half is due
    logic                  rev_q;       // reversal for this frame
    logic [WB_ADR_W-1:0]   line_cnt;    // href falls since vsync
    logic [WB_ADR_W-1:0]   col_cnt;     // pixels in current line
    logic                  pix_done;
    logic                  in_range;
    pixel_u                cam_w;
    pixel_u                sto_w;

    assign pix_done = vld_q && href_q && phase_q;                 // second byte here
    assign in_range = (line_cnt < V_ACT) && (col_cnt < H_ACT);    // inside geometry

    // camera order to storage order, red and blue trade places
    always_comb
    begin
        cam_w         = {hi_q, data_q};
        sto_w.sto.red = cam_w.cam.red;
        sto_w.sto.grn = cam_w.cam.grn;
        sto_w.sto.blu = cam_w.cam.blu;
    end

    ///////////////////////////////////////////////////////////////////////
    // control state
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i)
        begin
            vsync_q  <= 1'b0;
            href_q   <= 1'b0;
            href_d   <= 1'b0;
            vld_q    <= 1'b0;
            phase_q  <= 1'b0;
            rev_q    <= 1'b0;
            line_cnt <= '0;
            col_cnt  <= '0;
            push_o   <= 1'b0;
        end
        else
        begin
            vsync_q <= vsync_i;
            href_q  <= href_i;
            href_d  <= href_q;
            vld_q   <= byte_vld_i;
            if (vsync_q)
                rev_q <= reverse_i;                    // mode held for whole frame
            if (vsync_q || !href_q)
                phase_q <= 1'b0;                       // each line starts on upper byte
            else if (vld_q)
                phase_q <= ~phase_q;
            if (vsync_q)
                line_cnt <= '0;
            else if (href_d && !href_q)
                line_cnt <= line_cnt + 1'b1;           // falling href ends a line
            if (!href_q)
                col_cnt <= '0;
            else if (pix_done)
                col_cnt <= col_cnt + 1'b1;
            push_o <= pix_done && in_range && !vsync_q; // out-of-range pixels dropped
        end
    end

    // payload path
    always_ff @(posedge core_clk)
    begin
        data_q <= data_i;
        if (vld_q && !phase_q)
            hi_q <= data_q;                            // hold upper half
        pix_o <= sto_w ^ {PIX_W{rev_q}};               // invert all bits on reversal
        adr_o <= WB_ADR_W'(line_cnt * (2 * H_ACT) + H_BASE + col_cnt);
    end

    // sensor only drives bytes inside an active line
    a_byte_in_line : assert property (@(posedge core_clk) disable iff (rst_i)
        byte_vld_i |-> href_i);

endmodule

// File: capture/pixel_fifo.sv
`timescale 1ns/10ps

module pixel_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                         core_clk,
    input  logic                         rst_i,
    input  logic                         push_i,
    input  logic [video_pkg::PIX_W-1:0]  pix_i,
    input  logic [bus_pkg::WB_ADR_W-1:0] adr_i,
    input  logic                         pop_i,
    output logic [video_pkg::PIX_W-1:0]  pix_o,
    output logic [bus_pkg::WB_ADR_W-1:0] adr_o,
    output logic                         empty_o,
    output logic                         overflow_o
);
    import video_pkg::*;
    import bus_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [PIX_W-1:0]    pix_mem [FIFO_DEPTH];
    logic [WB_ADR_W-1:0] adr_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [PTR_W:0]      count;      // occupancy, 0 to FIFO_DEPTH
    logic                full;
    logic                wr_en;
    logic                rd_en;

    assign full    = (count == FIFO_DEPTH);
    assign empty_o = (count == 0);
    assign wr_en   = push_i && !full;        // push into full fifo is lost
    assign rd_en   = pop_i && !empty_o;
    assign pix_o   = pix_mem[rd_ptr];        // head word shown directly
    assign adr_o   = adr_mem[rd_ptr];

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (wr_en && !rd_en)
                count <= count + 1'b1;
            else if (rd_en && !wr_en)
                count <= count - 1'b1;
            if (push_i && full)
                overflow_o <= 1'b1;          // sticky until reset
        end
    end

    always_ff @(posedge core_clk)
    begin
        if (wr_en)
        begin
            pix_mem[wr_ptr] <= pix_i;
            adr_mem[wr_ptr] <= adr_i;
        end
    end

    a_no_pop_empty : assert property (@(posedge core_clk) disable iff (rst_i)
        pop_i |-> !empty_o);

endmodule

// File: common/bus_pkg.sv
package bus_pkg;

    ///////////////////////////////////////////////////////////////////////
    // wishbone classic widths
    ///////////////////////////////////////////////////////////////////////
    localparam int WB_ADR_W = 16;                 // word address
    localparam int WB_DAT_W = video_pkg::PIX_W;   // one pixel per word
    localparam int WB_SEL_W = 2;                  // byte lanes

endpackage

// File: common/video_pkg.sv
package video_pkg;

    ///////////////////////////////////////////////////////////////////////
    // rgb565 field widths
    ///////////////////////////////////////////////////////////////////////
    localparam int RED_W      = 5;
    localparam int GRN_W      = 6;
    localparam int BLU_W      = 5;
    localparam int PIX_W      = RED_W + GRN_W + BLU_W;  // 16 bit pixel
    localparam int CAM_BYTE_W = 8;                      // one sensor bus beat

    // default geometry per camera
    localparam int DEF_H_ACT  = 8;                      // pixels per line
    localparam int DEF_V_ACT  = 4;                      // lines per frame

    // one pixel word, read in camera order or in storage order
    typedef union packed {
        struct packed {
            logic [BLU_W-1:0] blu;                      // top bits from sensor
            logic [GRN_W-1:0] grn;
            logic [RED_W-1:0] red;
        } cam;
        struct packed {
            logic [RED_W-1:0] red;                      // top bits in memory
            logic [GRN_W-1:0] grn;
            logic [BLU_W-1:0] blu;
        } sto;
    } pixel_u;

endpackage

// File: dual_cam_store.f
common/video_pkg.sv
common/bus_pkg.sv
capture/cmos_byte_pack.sv
capture/pixel_fifo.sv
store/frame_writer.sv
logic/key_ctl.sv
logic/dual_cam_store_top.sv
testbench/tb_dual_cam_store.sv

// File: logic/dual_cam_store_top.sv
`timescale 1ns/10ps

module dual_cam_store_top #(
    parameter int H_ACT      = video_pkg::DEF_H_ACT,
    parameter int V_ACT      = video_pkg::DEF_V_ACT,
    parameter int FIFO_DEPTH = 8,
    parameter int CTRL_MAX   = 1
) (
    input  logic                             core_clk,
    input  logic                             rst_i,
    input  logic                             cam1_vsync_i,
    input  logic                             cam1_href_i,
    input  logic                             cam1_byte_vld_i,
    input  logic [video_pkg::CAM_BYTE_W-1:0] cam1_data_i,
    input  logic                             cam2_vsync_i,
    input  logic                             cam2_href_i,
    input  logic                             cam2_byte_vld_i,
    input  logic [video_pkg::CAM_BYTE_W-1:0] cam2_data_i,
    input  logic                             key_reverse_i,
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [bus_pkg::WB_ADR_W-1:0]     wb_adr_o,
    output logic [bus_pkg::WB_DAT_W-1:0]     wb_dat_o,
    output logic [bus_pkg::WB_SEL_W-1:0]     wb_sel_o,
    input  logic                             wb_ack_i,
    output logic                             overflow_o
);
    import video_pkg::*;
    import bus_pkg::*;

    logic [$clog2(CTRL_MAX + 1)-1:0] rev_mode;   // key driven mode
    logic                            rev_on;
    logic                            push1, push2;
    logic [PIX_W-1:0]                pix1, pix2;        // packer outputs
    logic [WB_ADR_W-1:0]             adr1, adr2;
    logic [PIX_W-1:0]                head_pix1, head_pix2;  // fifo heads
    logic [WB_ADR_W-1:0]             head_adr1, head_adr2;
    logic                            empty1, empty2;
    logic                            pop1, pop2;
    logic                            ovf1, ovf2;

    assign rev_on     = (rev_mode != '0);
    assign overflow_o = ovf1 | ovf2;              // either camera lost a pixel

    key_ctl #(
        .CTRL_MAX (CTRL_MAX)
    ) u_key (
        .core_clk (core_clk),
        .rst_i    (rst_i),
        .key_i    (key_reverse_i),
        .ctrl_o   (rev_mode)
    );

    ///////////////////////////////////////////////////////////////////////
    // camera 1 fills the left half, camera 2 the right half
    ///////////////////////////////////////////////////////////////////////
    cmos_byte_pack #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .H_BASE (0)
    ) u_pack1 (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .vsync_i    (cam1_vsync_i),
        .href_i     (cam1_href_i),
        .byte_vld_i (cam1_byte_vld_i),
        .data_i     (cam1_data_i),
        .reverse_i  (rev_on),
        .push_o     (push1),
        .pix_o      (pix1),
        .adr_o      (adr1)
    );

    cmos_byte_pack #(
        .H_ACT  (H_ACT),
        .V_ACT  (V_ACT),
        .H_BASE (H_ACT)
    ) u_pack2 (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .vsync_i    (cam2_vsync_i),
        .href_i     (cam2_href_i),
        .byte_vld_i (cam2_byte_vld_i),
        .data_i     (cam2_data_i),
        .reverse_i  (rev_on),
        .push_o     (push2),
        .pix_o      (pix2),
        .adr_o      (adr2)
    );

    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo1 (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .push_i     (push1),
        .pix_i      (pix1),
        .adr_i      (adr1),
        .pop_i      (pop1),
        .pix_o      (head_pix1),
        .adr_o      (head_adr1),
        .empty_o    (empty1),
        .overflow_o (ovf1)
    );

    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo2 (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .push_i     (push2),
        .pix_i      (pix2),
        .adr_i      (adr2),
        .pop_i      (pop2),
        .pix_o      (head_pix2),
        .adr_o      (head_adr2),
        .empty_o    (empty2),
        .overflow_o (ovf2)
    );

    frame_writer u_writer (
        .core_clk   (core_clk),
        .rst_i      (rst_i),
        .c1_empty_i (empty1),
        .c1_pix_i   (head_pix1),
        .c1_adr_i   (head_adr1),
        .c2_empty_i (empty2),
        .c2_pix_i   (head_pix2),
        .c2_adr_i   (head_adr2),
        .wb_ack_i   (wb_ack_i),
        .c1_pop_o   (pop1),
        .c2_pop_o   (pop2),
        .wb_cyc_o   (wb_cyc_o),
        .wb_stb_o   (wb_stb_o),
        .wb_we_o    (wb_we_o),
        .wb_adr_o   (wb_adr_o),
        .wb_dat_o   (wb_dat_o),
        .wb_sel_o   (wb_sel_o)
    );

endmodule

// File: logic/key_ctl.sv
`timescale 1ns/10ps

module key_ctl #(
    parameter int CTRL_MAX = 1
) (
    input  logic                              core_clk,
    input  logic                              rst_i,
    input  logic                              key_i,
    output logic [$clog2(CTRL_MAX + 1)-1:0]   ctrl_o
);
    logic key_s1;       // first sync flop
    logic key_s2;       // second sync flop
    logic key_s3;       // edge reference
    logic key_rise;

    assign key_rise = key_s2 && !key_s3;

    always_ff @(posedge core_clk)
    begin
        if (rst_i)
        begin
            key_s1 <= 1'b0;
            key_s2 <= 1'b0;
            key_s3 <= 1'b0;
            ctrl_o <= '0;
        end
        else
        begin
            key_s1 <= key_i;
            key_s2 <= key_s1;
            key_s3 <= key_s2;
            if (key_rise)
                ctrl_o <= (ctrl_o == CTRL_MAX) ? '0 : ctrl_o + 1'b1;  // wrap to 0
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile with verilator and run, exit status follows the testbench
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dual_cam_store -f dual_cam_store.f \
    --Mdir obj_dir -o sim_dual_cam_store &&
./obj_dir/sim_dual_cam_store || { echo "simulation did not pass"; exit 1; }

// File: store/frame_writer.sv
`timescale 1ns/10ps

module frame_writer (
    input  logic                         core_clk,
    input  logic                         rst_i,
    input  logic                         c1_empty_i,
    input  logic [video_pkg::PIX_W-1:0]  c1_pix_i,
    input  logic [bus_pkg::WB_ADR_W-1:0] c1_adr_i,
    input  logic                         c2_empty_i,
    input  logic [video_pkg::PIX_W-1:0]  c2_pix_i,
    input  logic [bus_pkg::WB_ADR_W-1:0] c2_adr_i,
    input  logic                         wb_ack_i,
    output logic                         c1_pop_o,
    output logic                         c2_pop_o,
    output logic                         wb_cyc_o,
    output logic                         wb_stb_o,
    output logic                         wb_we_o,
    output logic [bus_pkg::WB_ADR_W-1:0] wb_adr_o,
    output logic [bus_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic [bus_pkg::WB_SEL_W-1:0] wb_sel_o
);
    import bus_pkg::*;

    localparam logic S_IDLE = 1'b0;
    localparam logic S_STB  = 1'b1;

    logic state_q;
    logic last_c2_q;     // camera 2 got the previous slot
    logic take1;
    logic take2;

    // round robin, the camera not served last wins a tie
    assign take2    = !c2_empty_i && (c1_empty_i || !last_c2_q);
    assign take1    = !c1_empty_i && !take2;
    assign c1_pop_o = (state_q == S_IDLE) && take1;   // pop as head is captured
    assign c2_pop_o = (state_q == S_IDLE) && take2;
    assign wb_sel_o = {WB_SEL_W{wb_stb_o}};           // full word writes

    ///////////////////////////////////////////////////////////////////////
    // bus FSM
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge core_clk)
    begin
        if (rst_i)
        begin
            state_q   <= S_IDLE;
            last_c2_q <= 1'b0;
            wb_cyc_o  <= 1'b0;
            wb_stb_o  <= 1'b0;
            wb_we_o   <= 1'b0;
        end
        else
        begin
            case (state_q)
                S_IDLE:
                begin
                    if (take1 || take2)
                    begin
                        state_q   <= S_STB;
                        last_c2_q <= take2;
                        wb_cyc_o  <= 1'b1;     // cyc, stb, we rise together
                        wb_stb_o  <= 1'b1;
                        wb_we_o   <= 1'b1;
                    end
                end
                S_STB:
                begin
                    if (wb_ack_i)
                    begin
                        state_q  <= S_IDLE;    // one idle cycle follows
                        wb_cyc_o <= 1'b0;
                        wb_stb_o <= 1'b0;
                        wb_we_o  <= 1'b0;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // address and data load only while idle, so they hold until ack
    always_ff @(posedge core_clk)
    begin
        if (state_q == S_IDLE)
        begin
            wb_adr_o <= take2 ? c2_adr_i : c1_adr_i;
            wb_dat_o <= take2 ? c2_pix_i : c1_pix_i;
        end
    end

    a_stb_in_cyc : assert property (@(posedge core_clk) disable iff (rst_i)
        wb_stb_o |-> wb_cyc_o);

    a_hold_till_ack : assert property (@(posedge core_clk) disable iff (rst_i)
        wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o) && $stable(wb_dat_o));

endmodule

// File: testbench/tb_dual_cam_store.sv
`timescale 1ns/10ps

module tb_dual_cam_store;
    import video_pkg::*;
    import bus_pkg::*;

    localparam int H_ACT      = DEF_H_ACT;
    localparam int V_ACT      = DEF_V_ACT;
    localparam int FIFO_DEPTH = 8;
    localparam int MEM_WORDS  = 2 * H_ACT * V_ACT;            // both halves
    localparam int VSYNC_CYC  = 3;
    localparam int VPOST      = 4;                            // vsync low to first line
    localparam int HBLANK     = 10 * H_ACT;                   // writer drains each line
    localparam int LINE_MAX   = (H_ACT + 3) * 2 * 4 + HBLANK; // widest line, longest gaps
    localparam int FRAME_MAX  = VSYNC_CYC + VPOST + (V_ACT + 2) * LINE_MAX;
    localparam int SETTLE     = 20;
    localparam int DRAIN_MAX  = MEM_WORDS * 5 + SETTLE;       // 5 cycles per write at worst
    localparam int KEY_CYC    = 12;
    localparam int NUM_FRAMES = 5;
    localparam int CYC_LIMIT  = 2 * (NUM_FRAMES * (FRAME_MAX + DRAIN_MAX + KEY_CYC) + 20);

    logic                  core_clk;
    logic                  rst_i;
    logic                  cam1_vsync;
    logic                  cam1_href;
    logic                  cam1_vld;
    logic [CAM_BYTE_W-1:0] cam1_data;
    logic                  cam2_vsync;
    logic                  cam2_href;
    logic                  cam2_vld;
    logic [CAM_BYTE_W-1:0] cam2_data;
    logic                  key_rev;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [WB_ADR_W-1:0]   wb_adr;
    logic [WB_DAT_W-1:0]   wb_dat;
    logic [WB_SEL_W-1:0]   wb_sel;
    logic                  wb_ack;
    logic                  overflow;

    pixel_u mem     [MEM_WORDS];    // slave memory contents
    pixel_u exp_mem [MEM_WORDS];    // expected image
    bit     exp_hit [MEM_WORDS];    // address still due in this test
    int     exp_total;
    int     wr_count;
    int     ack_wait;
    int     seed;
    int     cycle;
    logic   rev_state;              // reversal mode after the last key press
    string  test_name;

    dual_cam_store_top #(
        .H_ACT      (H_ACT),
        .V_ACT      (V_ACT),
        .FIFO_DEPTH (FIFO_DEPTH),
        .CTRL_MAX   (1)
    ) UUT (
        .core_clk        (core_clk),
        .rst_i           (rst_i),
        .cam1_vsync_i    (cam1_vsync),
        .cam1_href_i     (cam1_href),
        .cam1_byte_vld_i (cam1_vld),
        .cam1_data_i     (cam1_data),
        .cam2_vsync_i    (cam2_vsync),
        .cam2_href_i     (cam2_href),
        .cam2_byte_vld_i (cam2_vld),
        .cam2_data_i     (cam2_data),
        .key_reverse_i   (key_rev),
        .wb_cyc_o        (wb_cyc),
        .wb_stb_o        (wb_stb),
        .wb_we_o         (wb_we),
        .wb_adr_o        (wb_adr),
        .wb_dat_o        (wb_dat),
        .wb_sel_o        (wb_sel),
        .wb_ack_i        (wb_ack),
        .overflow_o      (overflow)
    );

    // expected memory word for one camera word
    function automatic pixel_u ref_store_word(input logic [PIX_W-1:0] cam_word, input logic rev);
        pixel_u c;
        pixel_u s;
        c         = cam_word;
        s.sto.red = c.cam.red;          // red moves to the top field
        s.sto.grn = c.cam.grn;
        s.sto.blu = c.cam.blu;          // blue moves to the bottom field
        if (rev)
            s = pixel_u'(~s);           // reversal flips every bit
        return s;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_pix(input string name, input pixel_u exp, input pixel_u act);
        if (exp !== act)
        begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "pixel check");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "flag check");
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // clock, cycle limit, overflow monitor
    ///////////////////////////////////////////////////////////////////////
    initial
    begin
        core_clk = 1'b0;
        forever
            #4 core_clk = ~core_clk;    // 8 ns period
    end

    always @(negedge core_clk)
    begin
        cycle = cycle + 1;
        if (cycle >= CYC_LIMIT)
            abort_run("timeout, the writes did not finish within the cycle limit");
        else if (!rst_i)
            check_flag("overflow monitor", 1'b0, overflow);   // fifos never fill here
    end

    ///////////////////////////////////////////////////////////////////////
    // wishbone slave memory, acks after 0 to 3 cycles
    ///////////////////////////////////////////////////////////////////////
    task automatic store_write();
        int a;
        a = int'(wb_adr);
        if (a >= MEM_WORDS)
            abort_run($sformatf("write to address %0d, outside the memory", a));
        else if (!exp_hit[a])
            abort_run($sformatf("write to address %0d, not expected in %s", a, test_name));
        else
        begin
            check_flag({test_name, " cyc"}, 1'b1, wb_cyc);
            check_flag({test_name, " we"}, 1'b1, wb_we);
            check_flag({test_name, " sel"}, 1'b1, &wb_sel);
            check_pix($sformatf("%s adr %0d", test_name, a), exp_mem[a], wb_dat);
            mem[a]     = wb_dat;
            exp_hit[a] = 1'b0;          // second write to it would fail
            wr_count   = wr_count + 1;
        end
    endtask

    always @(negedge core_clk)
    begin
        if (rst_i)
        begin
            wb_ack   = 1'b0;
            ack_wait = -1;
        end
        else if (wb_ack)
            wb_ack = 1'b0;              // stb drops after the acked edge
        else if (wb_stb)
        begin
            if (ack_wait < 0)
                ack_wait = $unsigned($random(seed)) % 4;
            if (ack_wait == 0)
            begin
                store_write();          // commits at the next rising edge
                wb_ack   = 1'b1;
                ack_wait = -1;
            end
            else
                ack_wait = ack_wait - 1;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // camera stimulus
    ///////////////////////////////////////////////////////////////////////
    task automatic drive_cam(input int cam, input logic vs, input logic hr, input logic vld,
                             input logic [CAM_BYTE_W-1:0] dat);
        if (cam == 1)
        begin
            cam1_vsync = vs;
            cam1_href  = hr;
            cam1_vld   = vld;
            cam1_data  = dat;
        end
        else
        begin
            cam2_vsync = vs;
            cam2_href  = hr;
            cam2_vld   = vld;
            cam2_data  = dat;
        end
    endtask

    // one frame of random pixels, in-geometry ones go to the expected image
    task automatic send_frame(input int cam, input int lines, input int pix);
        int               base;
        int               gap;
        int               a;
        logic [PIX_W-1:0] word;
        base = (cam == 1) ? 0 : H_ACT;
        repeat (VSYNC_CYC)
        begin
            @(negedge core_clk);
            drive_cam(cam, 1'b1, 1'b0, 1'b0, '0);
        end
        repeat (VPOST)
        begin
            @(negedge core_clk);
            drive_cam(cam, 1'b0, 1'b0, 1'b0, '0);
        end
        for (int l = 0; l < lines; l++)
        begin
            for (int p = 0; p < pix; p++)
            begin
                word = PIX_W'($random(seed));
                if (l < V_ACT && p < H_ACT)
                begin
                    a          = l * 2 * H_ACT + base + p;
                    exp_mem[a] = ref_store_word(word, rev_state);
                    exp_hit[a] = 1'b1;
                    exp_total  = exp_total + 1;
                end
                for (int b = 0; b < 2; b++)
                begin
                    @(negedge core_clk);
                    drive_cam(cam, 1'b0, 1'b1, 1'b1, (b == 0) ? word[15:8] : word[7:0]);
                    gap = 1 + $unsigned($random(seed)) % 3;
                    repeat (gap)
                    begin
                        @(negedge core_clk);
                        drive_cam(cam, 1'b0, 1'b1, 1'b0, '0);
                    end
                end
            end
            repeat (HBLANK)
            begin
                @(negedge core_clk);
                drive_cam(cam, 1'b0, 1'b0, 1'b0, '0);   // href low ends the line
            end
        end
    endtask

    task automatic press_key();
        @(negedge core_clk);
        key_rev = 1'b1;
        repeat (4) @(negedge core_clk);
        key_rev = 1'b0;
        repeat (6) @(negedge core_clk);    // mode follows 3 cycles after the edge
        rev_state = ~rev_state;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        wr_count  = 0;
        exp_total = 0;
        for (int a = 0; a < MEM_WORDS; a++)
            exp_hit[a] = 1'b0;
    endtask

    task automatic wait_drain();
        while (wr_count < exp_total)
            @(negedge core_clk);
        repeat (SETTLE) @(negedge core_clk);   // room for any stray write
        check_flag({test_name, " cyc idle"}, 1'b0, wb_cyc);
        check_flag({test_name, " overflow"}, 1'b0, overflow);
    endtask

    task automatic check_memory();
        for (int a = 0; a < MEM_WORDS; a++)
            check_pix($sformatf("%s mem %0d", test_name, a), exp_mem[a], mem[a]);
    endtask

    ///////////////////////////////////////////////////////////////////////
    // test sequence
    ///////////////////////////////////////////////////////////////////////
    initial
    begin
        seed      = 53;
        cycle     = 0;
        rev_state = 1'b0;
        rst_i     = 1'b1;
        key_rev   = 1'b0;
        wb_ack    = 1'b0;
        ack_wait  = -1;
        drive_cam(1, 1'b0, 1'b0, 1'b0, '0);
        drive_cam(2, 1'b0, 1'b0, 1'b0, '0);
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            mem[a]     = pixel_u'(16'hC3A5 ^ PIX_W'(a) ^ (PIX_W'(a) << 9));  // per address fill
            exp_mem[a] = mem[a];
        end
        begin_test("reset idle");
        repeat (2) @(negedge core_clk);
        rst_i = 1'b0;
        repeat (10)
        begin
            @(negedge core_clk);
            check_flag("reset idle cyc", 1'b0, wb_cyc);
            check_flag("reset idle stb", 1'b0, wb_stb);
            check_flag("reset idle we", 1'b0, wb_we);
            check_flag("reset idle overflow", 1'b0, overflow);
        end

        begin_test("cam1 frame");          // left half only
        send_frame(1, V_ACT, H_ACT);
        wait_drain();
        check_memory();

        begin_test("dual frame");
        fork
            send_frame(1, V_ACT, H_ACT);
            send_frame(2, V_ACT, H_ACT);
        join
        wait_drain();
        check_memory();

        press_key();
        begin_test("reversed frame");
        fork
            send_frame(1, V_ACT, H_ACT);
            send_frame(2, V_ACT, H_ACT);
        join
        wait_drain();
        check_memory();

        press_key();
        begin_test("restored frame");
        fork
            send_frame(1, V_ACT, H_ACT);
            send_frame(2, V_ACT, H_ACT);
        join
        wait_drain();
        check_memory();

        begin_test("oversize frame");      // extra lines and pixels are dropped
        fork
            send_frame(1, V_ACT + 2, H_ACT + 3);
            send_frame(2, V_ACT + 2, H_ACT + 3);
        join
        wait_drain();
        check_memory();

        $display("Testbench passed");
        $finish;
    end

endmodule
